// ==== common/fetch_if.sv ====
`timescale 1ns/1ps

// Line transfer from the fetch stage into the instruction queue
interface fetch_if;

    fetch_pkg::addr_t line_pc;
    fetch_pkg::line_t line;
    logic             line_ready;  // Both halves present this cycle
    logic             flush;       // Redirect taken this cycle
    logic             stall;       // Not enough room for a whole line

    modport fetch (
        output line_pc,
        output line,
        output line_ready,
        output flush,
        input  stall
    );

    modport buffer (
        input  line_pc,
        input  line,
        input  line_ready,
        input  flush,
        output stall
    );

endinterface

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  instr_t;
    typedef logic [63:0]  bank_data_t;     // Two instructions from one bank
    typedef logic [127:0] line_t;          // Bank 1 in the upper half
    typedef logic [4:0]   reg_idx_t;

    localparam int BUFFER_DEPTH = 8;       // Power of two, pointers wrap
    localparam int LINE_INSTRS  = 4;

    localparam int PTR_WIDTH   = $clog2(BUFFER_DEPTH);
    localparam int COUNT_WIDTH = $clog2(BUFFER_DEPTH + 1);

    typedef logic [PTR_WIDTH-1:0]   ptr_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    localparam addr_t LINE_BYTES  = 32'd16;
    localparam addr_t BANK_BYTES  = 32'd8;
    localparam addr_t INSTR_BYTES = 32'd4;
    localparam addr_t RESET_PC    = 32'h0000_0000;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_BUSY,
        FETCH_CTRL,
        FETCH_INV
    } fetch_state_t;

endpackage

// ==== common/issue_if.sv ====
`timescale 1ns/1ps

interface issue_if;

    fetch_pkg::addr_t  head_pc0;
    fetch_pkg::addr_t  head_pc1;
    fetch_pkg::instr_t head_instr0;
    fetch_pkg::instr_t head_instr1;
    logic              head_valid0;
    logic              head_valid1;   // Only with head_valid0
    logic              pop_one;
    logic              pop_two;       // Never together with pop_one

    modport buffer (
        output head_pc0,
        output head_pc1,
        output head_instr0,
        output head_instr1,
        output head_valid0,
        output head_valid1,
        input  pop_one,
        input  pop_two
    );

    modport issue (
        input  head_pc0,
        input  head_pc1,
        input  head_instr0,
        input  head_instr1,
        input  head_valid0,
        input  head_valid1,
        output pop_one,
        output pop_two
    );

endinterface

// ==== fetch/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                  clock,
    input  logic                  reset,
    fetch_if.fetch                fetch,
    output logic                  imem0_valid,
    output fetch_pkg::addr_t      imem0_addr,
    input  logic                  imem0_ready,
    input  fetch_pkg::bank_data_t imem0_rdata,
    output logic                  imem1_valid,
    output fetch_pkg::addr_t      imem1_addr,
    input  logic                  imem1_ready,
    input  fetch_pkg::bank_data_t imem1_rdata,
    input  logic                  clear,
    input  logic                  trap,
    input  fetch_pkg::addr_t      mtvec,
    input  logic                  mret,
    input  fetch_pkg::addr_t      mepc,
    input  logic                  miss,
    input  fetch_pkg::addr_t      miss_addr,
    input  logic                  fence,
    input  fetch_pkg::addr_t      fence_npc
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;
    fetch_pkg::addr_t        pc;            // Address of the request in flight
    fetch_pkg::addr_t        pc_next;
    fetch_pkg::bank_data_t   data0;
    fetch_pkg::bank_data_t   data1;
    fetch_pkg::bank_data_t   data0_next;
    fetch_pkg::bank_data_t   data1_next;
    logic                    held0;
    logic                    held1;
    logic                    held0_next;
    logic                    held1_next;
    logic                    line_in_hand;
    logic                    step_stall;
    logic                    spec;
    logic                    fence_step;
    logic                    req_valid;
    logic                    line_out;

    // Each bank may answer in a different cycle, so keep the early half
    always_comb begin
        data0_next   = imem0_ready ? imem0_rdata : data0;
        data1_next   = imem1_ready ? imem1_rdata : data1;
        line_in_hand = (held0 | imem0_ready) & (held1 | imem1_ready);
        held0_next   = line_in_hand ? 1'b0 : (held0 | imem0_ready);
        held1_next   = line_in_hand ? 1'b0 : (held1 | imem1_ready);
    end

    // Only a useful line in BUSY with room downstream moves pc on
    assign step_stall = fetch.stall || (state != fetch_pkg::FETCH_BUSY) || !line_in_hand;

    always_comb begin
        spec       = 1'b1;
        fence_step = 1'b0;
        pc_next    = pc;
        if (clear) begin
            pc_next = fetch_pkg::RESET_PC;
        end else if (trap) begin
            pc_next = mtvec;
        end else if (mret) begin
            pc_next = mepc;
        end else if (miss) begin
            pc_next = miss_addr;
        end else if (fence) begin
            pc_next    = fence_npc;
            fence_step = 1'b1;
        end else begin
            spec = 1'b0;
            if (!step_stall) begin
                pc_next = pc + fetch_pkg::LINE_BYTES;
            end
        end
    end

    always_comb begin
        state_next = state;
        req_valid  = 1'b0;
        line_out   = line_in_hand;
        case (state)
            fetch_pkg::FETCH_IDLE: begin
                if (reset && !clear) begin   // Quiet while reset is held
                    state_next = fetch_pkg::FETCH_BUSY;
                    req_valid  = 1'b1;
                end
            end
            fetch_pkg::FETCH_BUSY: begin
                if (line_in_hand) begin
                    req_valid = 1'b1;        // Same pc again when stalled
                end else if (fence_step) begin
                    state_next = fetch_pkg::FETCH_INV;
                end else if (spec) begin
                    state_next = fetch_pkg::FETCH_CTRL;
                end
            end
            fetch_pkg::FETCH_CTRL,
            fetch_pkg::FETCH_INV: begin
                line_out = 1'b0;             // Stale line from the old path
                if (line_in_hand) begin
                    state_next = fetch_pkg::FETCH_BUSY;
                    req_valid  = 1'b1;
                end
            end
            default: begin
                state_next = fetch_pkg::FETCH_IDLE;
                line_out   = 1'b0;
            end
        endcase
    end

    assign imem0_valid = req_valid;
    assign imem1_valid = req_valid;
    assign imem0_addr  = pc_next;
    assign imem1_addr  = pc_next + fetch_pkg::BANK_BYTES;

    assign fetch.line_pc    = pc;
    assign fetch.line       = {data1_next, data0_next};
    assign fetch.line_ready = line_out;
    assign fetch.flush      = spec;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= fetch_pkg::FETCH_IDLE;
            pc    <= fetch_pkg::RESET_PC;
            held0 <= 1'b0;
            held1 <= 1'b0;
        end else begin
            state <= state_next;
            pc    <= pc_next;
            held0 <= held0_next;
            held1 <= held1_next;
        end
    end

    always_ff @(posedge clock) begin
        data0 <= data0_next;
        data1 <= data1_next;
    end

endmodule

// ==== project.f ====
common/fetch_pkg.sv
common/fetch_if.sv
common/issue_if.sv
fetch/fetch_stage.sv
verilog/fetch_buffer.sv
verilog/issue_stage.sv
verilog/frontend_top.sv
verif/tb_clock.sv
verif/frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module frontend_tb -f project.f

output=$(./obj_dir/Vfrontend_tb)
echo "$output"

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi

// ==== verif/frontend_tb.sv ====
`timescale 1ns/1ps

module frontend_tb;

    localparam int TIMEOUT_CYCLES = 4000;   // Six tests of up to ~400 cycles each
    localparam int WAIT_LIMIT     = 400;

    logic                        clock;
    logic                        reset;
    logic [1:0]                  req_valid;
    fetch_pkg::addr_t [1:0]      req_addr;
    logic [1:0]                  rsp_ready = '0;
    fetch_pkg::bank_data_t [1:0] rsp_data = '0;
    logic                        clear;
    logic                        trap;
    logic                        mret;
    logic                        miss;
    logic                        fence;
    fetch_pkg::addr_t            mtvec;
    fetch_pkg::addr_t            mepc;
    fetch_pkg::addr_t            miss_addr;
    fetch_pkg::addr_t            fence_npc;
    logic                        halt = 1'b0;
    logic                        issue_valid0;
    fetch_pkg::addr_t            issue_pc0;
    fetch_pkg::instr_t           issue_instr0;
    logic                        issue_valid1;
    fetch_pkg::addr_t            issue_pc1;
    fetch_pkg::instr_t           issue_instr1;

    int                     seed = 27481;
    logic                   chain_mode = 1'b0;     // Word layout the banks return
    logic                   halt_enable = 1'b0;
    logic [1:0]             pending = '0;
    fetch_pkg::addr_t [1:0] bank_addr;
    int                     wait_cnt [2];
    fetch_pkg::addr_t       expected_pc = fetch_pkg::RESET_PC;
    logic                   sb_mode = 1'b0;        // Word layout the scoreboard expects
    fetch_pkg::addr_t       redirect_target;
    logic                   redirect_mode;
    int                     redirect_seq = 0;
    int                     accepted_seq = 0;
    int                     closed_seq = 0;        // Redirect whose old-path window is over
    logic                   halt_sampled = 1'b0;
    int                     issued_count = 0;
    int                     pair_count = 0;
    int                     cycle_count = 0;
    int                     check_errors = 0;
    int                     test_errors = 0;
    int                     bank_errors = 0;

    tb_clock i_tb_clock (.clock(clock), .reset(reset));

    frontend_top i_dut (
        .imem0_valid (req_valid[0]),
        .imem0_addr  (req_addr[0]),
        .imem0_ready (rsp_ready[0]),
        .imem0_rdata (rsp_data[0]),
        .imem1_valid (req_valid[1]),
        .imem1_addr  (req_addr[1]),
        .imem1_ready (rsp_ready[1]),
        .imem1_rdata (rsp_data[1]),
        .*
    );

    // Chain mode makes each rs1 the previous word's rd
    function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::addr_t a, input logic chain);
        fetch_pkg::addr_t    prev;
        fetch_pkg::reg_idx_t rd;
        fetch_pkg::reg_idx_t rs1;
        fetch_pkg::reg_idx_t rs2;
        prev = a - 4;
        if (chain) begin
            rd  = {a[5:2], 1'b1};            // Odd, never x0
            rs1 = {prev[5:2], 1'b1};
            rs2 = a[10:6];
        end else begin
            rd  = {1'b1, a[5:2]};            // x16 to x31, sources stay below
            rs1 = {1'b0, a[5:2]};
            rs2 = {1'b0, a[9:6]};
        end
        return {a[16:10], rs2, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    task automatic check_addr(input string name, input fetch_pkg::addr_t expected,
                              input fetch_pkg::addr_t actual);
        if (actual !== expected) begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_instr(input string name, input fetch_pkg::instr_t expected,
                               input fetch_pkg::instr_t actual);
        if (actual !== expected) begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    // Bank models with 1 to 3 cycles of latency, plus the random halt pattern
    always @(posedge clock) begin
        int draw;
        for (int b = 0; b < 2; b++) begin
            rsp_ready[b] <= 1'b0;
            if (!reset) begin
                pending[b] = 1'b0;
                if (req_valid[b]) begin
                    bank_errors++;
                    $display("ERROR at %0t ns: bank %0d got a request while reset was held",
                             $time, b);
                end
            end else begin
                if (req_valid[b]) begin
                    if (pending[b]) begin
                        bank_errors++;
                        $display("ERROR at %0t ns: bank %0d got a second request in flight",
                                 $time, b);
                    end
                    draw         = $random(seed);
                    pending[b]   = 1'b1;
                    bank_addr[b] = req_addr[b];
                    wait_cnt[b]  = int'(unsigned'(draw) % 3);
                end else if (pending[b] && wait_cnt[b] != 0) begin
                    wait_cnt[b] = wait_cnt[b] - 1;
                end
                if (pending[b] && wait_cnt[b] == 0) begin
                    rsp_ready[b] <= 1'b1;
                    rsp_data[b]  <= {mem_word(bank_addr[b] + 4, chain_mode),
                                     mem_word(bank_addr[b], chain_mode)};
                    pending[b]   = 1'b0;
                end
            end
        end
        if (halt_enable) begin
            draw = $random(seed);
            if (draw[3:0] == 4'd0) begin
                halt <= !halt;
            end
        end else begin
            halt <= 1'b0;
        end
    end

    // Scoreboard on the registered issue outputs
    always @(posedge clock) begin
        if (reset) begin
            if (halt_sampled && (issue_valid0 || issue_valid1)) begin
                check_errors++;
                $display("ERROR at %0t ns: issue valid high in the cycle after halt", $time);
            end
            halt_sampled = halt;
            if (issue_valid0) begin
                // Once the old path has drained the next issue must be the target
                if (redirect_seq != accepted_seq
                        && (issue_pc0 == redirect_target || closed_seq == redirect_seq)) begin
                    accepted_seq = redirect_seq;
                    sb_mode      = redirect_mode;
                    expected_pc  = redirect_target;
                end
                check_addr("issue_pc0", expected_pc, issue_pc0);
                check_instr("issue_instr0", mem_word(expected_pc, sb_mode), issue_instr0);
                expected_pc = expected_pc + 4;
                issued_count++;
            end
            if (issue_valid1) begin
                if (!issue_valid0 || sb_mode) begin
                    check_errors++;
                    $display("ERROR at %0t ns: slot 1 issued alone or across a hazard", $time);
                end
                check_addr("issue_pc1", expected_pc, issue_pc1);
                check_instr("issue_instr1", mem_word(expected_pc, sb_mode), issue_instr1);
                expected_pc = expected_pc + 4;
                issued_count++;
                pair_count++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    task automatic wait_for_issues(input int n);
        int target;
        int cycles;
        target = issued_count + n;
        cycles = 0;
        while (issued_count < target && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (issued_count < target) begin
            test_errors++;
            $display("ERROR at %0t ns: issue stream stopped short of %0d instructions", $time, n);
        end
    endtask

    // Called in the cycle the redirect pulse is driven
    task automatic follow_redirect(input fetch_pkg::addr_t target, input logic chain);
        int cycles;
        redirect_target <= target;
        redirect_mode   <= chain;
        redirect_seq    <= redirect_seq + 1;
        chain_mode      <= chain;
        @(posedge clock);
        clear <= 1'b0;
        trap  <= 1'b0;
        mret  <= 1'b0;
        miss  <= 1'b0;
        fence <= 1'b0;
        @(posedge clock);
        closed_seq <= redirect_seq;   // Buffer flushed, old-path issues all seen
        cycles = 0;
        while (accepted_seq != redirect_seq && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (accepted_seq != redirect_seq) begin
            test_errors++;
            $display("ERROR at %0t ns: stream never resumed at 0x%08h", $time, target);
        end
        wait_for_issues(24);
    endtask

    task automatic test_sequential();
        wait_for_issues(64);
    endtask

    task automatic test_pairing();
        int pairs_before;
        pairs_before = pair_count;
        wait_for_issues(32);
        if (pair_count == pairs_before) begin
            test_errors++;
            $display("ERROR at %0t ns: no paired issue in independent mode", $time);
        end
        @(posedge clock);
        clear <= 1'b1;
        follow_redirect(fetch_pkg::RESET_PC, 1'b1);
        wait_for_issues(8);
    endtask

    task automatic test_redirect();
        @(posedge clock);
        miss      <= 1'b1;
        miss_addr <= 32'h0000_0400;
        follow_redirect(32'h0000_0400, 1'b0);
    endtask

    task automatic test_priority();
        @(posedge clock);
        trap      <= 1'b1;
        mret      <= 1'b1;
        miss      <= 1'b1;
        mtvec     <= 32'h0000_1000;
        mepc      <= 32'h0000_2000;
        miss_addr <= 32'h0000_3000;
        follow_redirect(32'h0000_1000, 1'b0);
        @(posedge clock);
        mret <= 1'b1;
        miss <= 1'b1;
        follow_redirect(32'h0000_2000, 1'b0);
        @(posedge clock);
        clear <= 1'b1;
        follow_redirect(fetch_pkg::RESET_PC, 1'b0);
    endtask

    task automatic test_fence();
        @(posedge clock);
        fence     <= 1'b1;
        fence_npc <= 32'h0000_0200;
        follow_redirect(32'h0000_0200, 1'b0);
    endtask

    task automatic test_halt();
        halt_enable <= 1'b1;
        repeat (200) @(posedge clock);
        halt_enable <= 1'b0;
        wait_for_issues(32);
    endtask

    initial begin
        clear     <= 1'b0;
        trap      <= 1'b0;
        mret      <= 1'b0;
        miss      <= 1'b0;
        fence     <= 1'b0;
        mtvec     <= '0;
        mepc      <= '0;
        miss_addr <= '0;
        fence_npc <= '0;
        while (reset !== 1'b1) @(posedge clock);
        test_sequential();
        test_pairing();
        test_redirect();
        test_priority();
        test_fence();
        test_halt();
        $display("errors: %0d check, %0d test, %0d bank", check_errors, test_errors, bank_errors);
        if (check_errors + test_errors + bank_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;   // 8 ns period
    end

    initial begin
        reset = 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b1;
    end

endmodule

// ==== verilog/fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer (
    input logic      clock,
    input logic      reset,
    fetch_if.buffer  fetch,
    issue_if.buffer  issue
);

    fetch_pkg::addr_t  pc_mem    [fetch_pkg::BUFFER_DEPTH];
    fetch_pkg::instr_t instr_mem [fetch_pkg::BUFFER_DEPTH];

    fetch_pkg::ptr_t   rd_ptr;
    fetch_pkg::ptr_t   wr_ptr;
    fetch_pkg::ptr_t   rd_ptr_next;
    fetch_pkg::count_t count;
    fetch_pkg::count_t pop_count;
    fetch_pkg::count_t push_count;
    logic              write_en;

    // Room for a whole line is needed before a write is accepted
    assign fetch.stall = count > fetch_pkg::count_t'(fetch_pkg::BUFFER_DEPTH
                                                     - fetch_pkg::LINE_INSTRS);

    assign write_en = fetch.line_ready && !fetch.stall && !fetch.flush;

    assign rd_ptr_next = rd_ptr + fetch_pkg::ptr_t'(1);

    assign issue.head_pc0    = pc_mem[rd_ptr];
    assign issue.head_instr0 = instr_mem[rd_ptr];
    assign issue.head_pc1    = pc_mem[rd_ptr_next];
    assign issue.head_instr1 = instr_mem[rd_ptr_next];
    assign issue.head_valid0 = count != '0;
    assign issue.head_valid1 = count > fetch_pkg::count_t'(1);

    always_comb begin
        if (issue.pop_two) begin
            pop_count = fetch_pkg::count_t'(2);
        end else if (issue.pop_one) begin
            pop_count = fetch_pkg::count_t'(1);
        end else begin
            pop_count = '0;
        end
        push_count = write_en ? fetch_pkg::count_t'(fetch_pkg::LINE_INSTRS) : '0;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (fetch.flush) begin
            rd_ptr <= '0;     // Old path gone, pending pops with it
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + fetch_pkg::ptr_t'(pop_count);
            if (write_en) begin
                wr_ptr <= wr_ptr + fetch_pkg::ptr_t'(fetch_pkg::LINE_INSTRS);
            end
            count <= count + push_count - pop_count;
        end
    end

    // Whole line lands in one edge, lowest address first
    always_ff @(posedge clock) begin
        if (write_en) begin
            for (int i = 0; i < fetch_pkg::LINE_INSTRS; i++) begin
                pc_mem[wr_ptr + fetch_pkg::ptr_t'(i)] <=
                    fetch.line_pc + fetch_pkg::addr_t'(i) * fetch_pkg::INSTR_BYTES;
                instr_mem[wr_ptr + fetch_pkg::ptr_t'(i)] <= fetch.line[i*32 +: 32];
            end
        end
    end

endmodule

// ==== verilog/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top (
    input  logic                  clock,
    input  logic                  reset,
    output logic                  imem0_valid,
    output fetch_pkg::addr_t      imem0_addr,
    input  logic                  imem0_ready,
    input  fetch_pkg::bank_data_t imem0_rdata,
    output logic                  imem1_valid,
    output fetch_pkg::addr_t      imem1_addr,
    input  logic                  imem1_ready,
    input  fetch_pkg::bank_data_t imem1_rdata,
    input  logic                  clear,
    input  logic                  trap,
    input  fetch_pkg::addr_t      mtvec,
    input  logic                  mret,
    input  fetch_pkg::addr_t      mepc,
    input  logic                  miss,
    input  fetch_pkg::addr_t      miss_addr,
    input  logic                  fence,
    input  fetch_pkg::addr_t      fence_npc,
    input  logic                  halt,
    output logic                  issue_valid0,
    output fetch_pkg::addr_t      issue_pc0,
    output fetch_pkg::instr_t     issue_instr0,
    output logic                  issue_valid1,
    output fetch_pkg::addr_t      issue_pc1,
    output fetch_pkg::instr_t     issue_instr1
);

    fetch_if i_fetch_if ();
    issue_if i_issue_if ();

    fetch_stage i_fetch_stage (
        .clock       (clock),
        .reset       (reset),
        .fetch       (i_fetch_if),
        .imem0_valid (imem0_valid),
        .imem0_addr  (imem0_addr),
        .imem0_ready (imem0_ready),
        .imem0_rdata (imem0_rdata),
        .imem1_valid (imem1_valid),
        .imem1_addr  (imem1_addr),
        .imem1_ready (imem1_ready),
        .imem1_rdata (imem1_rdata),
        .clear       (clear),
        .trap        (trap),
        .mtvec       (mtvec),
        .mret        (mret),
        .mepc        (mepc),
        .miss        (miss),
        .miss_addr   (miss_addr),
        .fence       (fence),
        .fence_npc   (fence_npc)
    );

    fetch_buffer i_fetch_buffer (
        .clock (clock),
        .reset (reset),
        .fetch (i_fetch_if),
        .issue (i_issue_if)
    );

    issue_stage i_issue_stage (
        .clock        (clock),
        .reset        (reset),
        .issue        (i_issue_if),
        .halt         (halt),
        .issue_valid0 (issue_valid0),
        .issue_pc0    (issue_pc0),
        .issue_instr0 (issue_instr0),
        .issue_valid1 (issue_valid1),
        .issue_pc1    (issue_pc1),
        .issue_instr1 (issue_instr1)
    );

endmodule

// ==== verilog/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
    input  logic              clock,
    input  logic              reset,
    issue_if.issue            issue,
    input  logic              halt,
    output logic              issue_valid0,
    output fetch_pkg::addr_t  issue_pc0,
    output fetch_pkg::instr_t issue_instr0,
    output logic              issue_valid1,
    output fetch_pkg::addr_t  issue_pc1,
    output fetch_pkg::instr_t issue_instr1
);

    fetch_pkg::reg_idx_t rd0;
    fetch_pkg::reg_idx_t rs1_1;
    fetch_pkg::reg_idx_t rs2_1;
    logic                hazard;
    logic                issue_any;
    logic                issue_pair;

    assign rd0   = issue.head_instr0[11:7];
    assign rs1_1 = issue.head_instr1[19:15];
    assign rs2_1 = issue.head_instr1[24:20];

    // x0 as destination never blocks the second slot
    assign hazard = (rd0 != '0) && ((rd0 == rs1_1) || (rd0 == rs2_1));

    assign issue_any  = !halt && issue.head_valid0;
    assign issue_pair = issue_any && issue.head_valid1 && !hazard;

    assign issue.pop_two = issue_pair;
    assign issue.pop_one = issue_any && !issue_pair;

    always_ff @(posedge clock) begin
        if (!reset) begin
            issue_valid0 <= 1'b0;
            issue_valid1 <= 1'b0;
        end else begin
            issue_valid0 <= issue_any;
            issue_valid1 <= issue_pair;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_any) begin
            issue_pc0    <= issue.head_pc0;
            issue_instr0 <= issue.head_instr0;
        end
        if (issue_pair) begin
            issue_pc1    <= issue.head_pc1;
            issue_instr1 <= issue.head_instr1;
        end
    end

endmodule
